// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_fe_mem
FLIST     ?= all.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

SRCS := $(filter-out +incdir+%,$(shell cat $(FLIST)))
HDRS := $(wildcard hw/*.svh)
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(FLIST) $(SRCS) $(HDRS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "Testbench passed"

clean:
	rm -rf $(OBJ_DIR)

// ==== all.f ====
+incdir+hw
hw/fe_mem_pkg.sv
hw/fe_mem_ctrl.sv
hw/itlb.sv
hw/pma_apb.sv
hw/icache.sv
hw/fe_mem_top.sv
verif/fe_mem_checker.sv
verif/tb_fe_mem.sv

// ==== hw/fe_mem_cfg.svh ====
`ifndef FE_MEM_CFG_SVH
`define FE_MEM_CFG_SVH

// address and instruction widths, 4 KiB pages.
`define FE_VADDR_W 32
`define FE_PTAG_W 20
`define FE_VTAG_W 20
`define FE_INSTR_W 32

`define FE_TLB_ELS 4

// direct mapped, one instruction per line.
`define FE_IC_SETS 16
`define FE_IC_IDX_W 4
`define FE_IC_OFF_W 6 // vaddr 11:6, above the index.
`define FE_IC_TAG_W 26 // ptag plus line offset bits.

// first dram page, lower pages are tile memory.
`define FE_DRAM_BASE_PTAG 20'h80000

`define FE_APB_DOMAIN_ADDR 4'h0
`define FE_APB_MODE_ADDR 4'h4

`endif

// ==== hw/fe_mem_ctrl.sv ====
`include "fe_mem_cfg.svh"

module fe_mem_ctrl (
   input  logic                      clk_i,
   input  logic                      reset_i,
   input  logic                      cmd_v_i,
   input  fe_mem_pkg::fe_op_e        cmd_op_i,
   input  logic [`FE_VTAG_W-1:0]     fetch_vtag_i,
   input  fe_mem_pkg::priv_e         priv_i,
   input  logic                      translation_en_i,
   input  logic                      poison_i,
   input  logic                      tlb_hit_i,
   input  fe_mem_pkg::tlb_entry_s    tlb_entry_i,
   input  logic                      uncached_i,
   input  logic [7:0]                domain_i,
   input  logic                      uncached_mode_i,
   input  logic                      ic_hit_i,
   input  logic [`FE_INSTR_W-1:0]    ic_data_i,
   output logic                      cmd_yumi_o,
   output logic                      fetch_v_o,
   output logic                      tlb_fill_v_o,
   output logic                      tlb_fence_v_o,
   output logic                      ic_fence_v_o,
   output logic [`FE_PTAG_W-1:0]     ptag_o,
   output logic                      resp_v_o,
   output logic [`FE_INSTR_W-1:0]    resp_data_o,
   output logic                      resp_itlb_miss_o,
   output logic                      resp_icache_miss_o,
   output logic                      resp_access_fault_o,
   output logic                      resp_page_fault_o
);

   logic                   s1_v_r;
   logic [`FE_VTAG_W-1:0]  s1_vtag_r;
   fe_mem_pkg::priv_e      s1_priv_r;
   logic                   s1_xlate_r;
   logic                   access_fault;
   logic                   page_fault;
   logic                   priv_fault;
   logic                   itlb_miss;

   // no back-pressure, every valid command is taken.
   assign cmd_yumi_o    = cmd_v_i;
   assign fetch_v_o     = cmd_v_i && (cmd_op_i == fe_mem_pkg::op_fetch);
   assign tlb_fill_v_o  = cmd_v_i && (cmd_op_i == fe_mem_pkg::op_tlb_fill);
   assign tlb_fence_v_o = cmd_v_i && (cmd_op_i == fe_mem_pkg::op_tlb_fence);
   assign ic_fence_v_o  = cmd_v_i && (cmd_op_i == fe_mem_pkg::op_icache_fence);

   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         s1_v_r <= 1'b0;
      end else begin
         s1_v_r <= fetch_v_o;
      end
   end

   // fetch context travels with the fetch into stage 1.
   always_ff @(posedge clk_i) begin
      if (fetch_v_o) begin
         s1_vtag_r  <= fetch_vtag_i;
         s1_priv_r  <= priv_i;
         s1_xlate_r <= translation_en_i;
      end
   end

   assign ptag_o = s1_xlate_r ? tlb_entry_i.ptag : s1_vtag_r;

   assign priv_fault = ((s1_priv_r == fe_mem_pkg::priv_s) && tlb_entry_i.u)
                     || ((s1_priv_r == fe_mem_pkg::priv_u) && !tlb_entry_i.u);
   assign page_fault = s1_xlate_r && tlb_hit_i && (priv_fault || !tlb_entry_i.x);
   assign itlb_miss  = s1_xlate_r && !tlb_hit_i;

   // mode, domain and local memory checks.
   assign access_fault = (uncached_mode_i && !uncached_i)
                       || !domain_i[ptag_o[`FE_PTAG_W-1 -: 3]]
                       || (ptag_o < `FE_DRAM_BASE_PTAG);

   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         resp_v_o <= 1'b0;
      end else begin
         resp_v_o <= s1_v_r && !poison_i; // poison kills in stage 1.
      end
   end

   always_ff @(posedge clk_i) begin
      if (s1_v_r) begin
         resp_data_o         <= ic_data_i;
         resp_itlb_miss_o    <= itlb_miss;
         resp_icache_miss_o  <= !ic_hit_i;
         resp_access_fault_o <= access_fault;
         resp_page_fault_o   <= page_fault;
      end
   end

endmodule

// ==== hw/fe_mem_pkg.sv ====
`include "fe_mem_cfg.svh"

package fe_mem_pkg;

   // command ops on the front end memory port.
   typedef enum logic [1:0] {
      op_fetch        = 2'd0,
      op_tlb_fill     = 2'd1,
      op_tlb_fence    = 2'd2,
      op_icache_fence = 2'd3
   } fe_op_e;

   typedef enum logic [1:0] {
      priv_u = 2'd0,
      priv_s = 2'd1
   } priv_e;

   // 22 bits.
   typedef struct packed {
      logic [`FE_PTAG_W-1:0] ptag;
      logic                  u; // user page.
      logic                  x; // executable.
   } tlb_entry_s;

endpackage

// ==== hw/fe_mem_top.sv ====
`include "fe_mem_cfg.svh"

module fe_mem_top (
   input  logic                     clk_i,
   input  logic                     reset_i,
   input  logic                     cmd_v_i,
   input  fe_mem_pkg::fe_op_e       cmd_op_i,
   input  logic [`FE_VADDR_W-1:0]   cmd_vaddr_i,
   input  logic [`FE_VTAG_W-1:0]    cmd_vtag_i,
   input  fe_mem_pkg::tlb_entry_s   cmd_entry_i,
   output logic                     cmd_yumi_o,
   input  fe_mem_pkg::priv_e        priv_i,
   input  logic                     translation_en_i,
   input  logic                     poison_i,
   input  logic                     psel_i,
   input  logic                     penable_i,
   input  logic                     pwrite_i,
   input  logic [3:0]               paddr_i,
   input  logic [31:0]              pwdata_i,
   output logic [31:0]              prdata_o,
   output logic                     pready_o,
   output logic                     pslverr_o,
   input  logic                     fill_v_i,
   input  logic [`FE_IC_IDX_W-1:0]  fill_index_i,
   input  logic [`FE_IC_TAG_W-1:0]  fill_tag_i,
   input  logic [`FE_INSTR_W-1:0]   fill_data_i,
   output logic                     resp_v_o,
   output logic [`FE_INSTR_W-1:0]   resp_data_o,
   output logic                     resp_itlb_miss_o,
   output logic                     resp_icache_miss_o,
   output logic                     resp_access_fault_o,
   output logic                     resp_page_fault_o
);

   logic                    fetch_v;
   logic                    tlb_fill_v;
   logic                    tlb_fence_v;
   logic                    ic_fence_v;
   logic                    tlb_hit;
   fe_mem_pkg::tlb_entry_s  tlb_entry;
   logic [`FE_PTAG_W-1:0]   ptag;
   logic                    uncached;
   logic [7:0]              domain;
   logic                    uncached_mode;
   logic                    ic_hit;
   logic [`FE_INSTR_W-1:0]  ic_data;

   fe_mem_ctrl ctrl (
      .clk_i               (clk_i),
      .reset_i             (reset_i),
      .cmd_v_i             (cmd_v_i),
      .cmd_op_i            (cmd_op_i),
      .fetch_vtag_i        (cmd_vaddr_i[31:12]),
      .priv_i              (priv_i),
      .translation_en_i    (translation_en_i),
      .poison_i            (poison_i),
      .tlb_hit_i           (tlb_hit),
      .tlb_entry_i         (tlb_entry),
      .uncached_i          (uncached),
      .domain_i            (domain),
      .uncached_mode_i     (uncached_mode),
      .ic_hit_i            (ic_hit),
      .ic_data_i           (ic_data),
      .cmd_yumi_o          (cmd_yumi_o),
      .fetch_v_o           (fetch_v),
      .tlb_fill_v_o        (tlb_fill_v),
      .tlb_fence_v_o       (tlb_fence_v),
      .ic_fence_v_o        (ic_fence_v),
      .ptag_o              (ptag),
      .resp_v_o            (resp_v_o),
      .resp_data_o         (resp_data_o),
      .resp_itlb_miss_o    (resp_itlb_miss_o),
      .resp_icache_miss_o  (resp_icache_miss_o),
      .resp_access_fault_o (resp_access_fault_o),
      .resp_page_fault_o   (resp_page_fault_o)
   );

   itlb itlb (
      .clk_i        (clk_i),
      .reset_i      (reset_i),
      .flush_i      (tlb_fence_v),
      .lookup_v_i   (fetch_v),
      .fill_v_i     (tlb_fill_v),
      .vtag_i       (cmd_vaddr_i[31:12]),
      .fill_vtag_i  (cmd_vtag_i),
      .fill_entry_i (cmd_entry_i),
      .hit_o        (tlb_hit),
      .entry_o      (tlb_entry)
   );

   pma_apb pma (
      .clk_i           (clk_i),
      .reset_i         (reset_i),
      .psel_i          (psel_i),
      .penable_i       (penable_i),
      .pwrite_i        (pwrite_i),
      .paddr_i         (paddr_i),
      .pwdata_i        (pwdata_i),
      .ptag_i          (ptag),
      .prdata_o        (prdata_o),
      .pready_o        (pready_o),
      .pslverr_o       (pslverr_o),
      .uncached_o      (uncached),
      .domain_o        (domain),
      .uncached_mode_o (uncached_mode)
   );

   // virtually indexed by vaddr 5:2.
   icache icache (
      .clk_i        (clk_i),
      .reset_i      (reset_i),
      .read_v_i     (fetch_v),
      .index_i      (cmd_vaddr_i[5:2]),
      .line_off_i   (cmd_vaddr_i[11:6]),
      .ptag_i       (ptag),
      .fence_i      (ic_fence_v),
      .fill_v_i     (fill_v_i),
      .fill_index_i (fill_index_i),
      .fill_tag_i   (fill_tag_i),
      .fill_data_i  (fill_data_i),
      .hit_o        (ic_hit),
      .data_o       (ic_data)
   );

endmodule

// ==== hw/icache.sv ====
`include "fe_mem_cfg.svh"

module icache (
   input  logic                     clk_i,
   input  logic                     reset_i,
   input  logic                     read_v_i,
   input  logic [`FE_IC_IDX_W-1:0]  index_i,
   input  logic [`FE_IC_OFF_W-1:0]  line_off_i,
   input  logic [`FE_PTAG_W-1:0]    ptag_i,
   input  logic                     fence_i,
   input  logic                     fill_v_i,
   input  logic [`FE_IC_IDX_W-1:0]  fill_index_i,
   input  logic [`FE_IC_TAG_W-1:0]  fill_tag_i,
   input  logic [`FE_INSTR_W-1:0]   fill_data_i,
   output logic                     hit_o,
   output logic [`FE_INSTR_W-1:0]   data_o
);

   logic [`FE_IC_SETS-1:0]   valid_r;
   logic [`FE_IC_TAG_W-1:0]  tag_mem_r [`FE_IC_SETS];
   logic [`FE_INSTR_W-1:0]   data_mem_r [`FE_IC_SETS];
   logic                     line_v_r;
   logic [`FE_IC_TAG_W-1:0]  line_tag_r;
   logic [`FE_INSTR_W-1:0]   line_data_r;
   logic [`FE_IC_OFF_W-1:0]  off_r;

   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         valid_r  <= '0;
         line_v_r <= 1'b0;
      end else begin
         if (fence_i) begin
            valid_r <= '0;
         end else if (fill_v_i) begin
            valid_r[fill_index_i] <= 1'b1;
         end
         if (read_v_i) begin
            line_v_r <= valid_r[index_i];
         end
      end
   end

   always_ff @(posedge clk_i) begin
      if (fill_v_i) begin
         tag_mem_r[fill_index_i]  <= fill_tag_i;
         data_mem_r[fill_index_i] <= fill_data_i;
      end
      // stage 0 read, used in stage 1.
      if (read_v_i) begin
         line_tag_r  <= tag_mem_r[index_i];
         line_data_r <= data_mem_r[index_i];
         off_r       <= line_off_i;
      end
   end

   // physical tag compare.
   assign hit_o  = line_v_r && (line_tag_r == {ptag_i, off_r});
   assign data_o = hit_o ? line_data_r : '0;

   // fill port and fence command are independent sources.
   fill_fence_excl_a: assert property (@(posedge clk_i) disable iff (reset_i)
      !(fill_v_i && fence_i));

endmodule

// ==== hw/itlb.sv ====
`include "fe_mem_cfg.svh"

module itlb (
   input  logic                      clk_i,
   input  logic                      reset_i,
   input  logic                      flush_i,
   input  logic                      lookup_v_i,
   input  logic                      fill_v_i,
   input  logic [`FE_VTAG_W-1:0]     vtag_i,
   input  logic [`FE_VTAG_W-1:0]     fill_vtag_i,
   input  fe_mem_pkg::tlb_entry_s    fill_entry_i,
   output logic                      hit_o,
   output fe_mem_pkg::tlb_entry_s    entry_o
);

   localparam int ptr_w = $clog2(`FE_TLB_ELS);

   logic [`FE_TLB_ELS-1:0]    valid_r;
   logic [`FE_VTAG_W-1:0]     vtag_mem_r [`FE_TLB_ELS];
   fe_mem_pkg::tlb_entry_s    entry_mem_r [`FE_TLB_ELS];
   logic [ptr_w-1:0]          rr_ptr_r;
   logic [`FE_TLB_ELS-1:0]    lookup_match;
   logic [`FE_TLB_ELS-1:0]    fill_match;
   logic [ptr_w-1:0]          fill_ptr;
   fe_mem_pkg::tlb_entry_s    lookup_entry;
   logic [`FE_TLB_ELS-1:0]    hit_vec_r;

   always_comb begin
      lookup_entry = '0;
      fill_ptr     = rr_ptr_r;
      for (int i = 0; i < `FE_TLB_ELS; i++) begin
         lookup_match[i] = valid_r[i] && (vtag_mem_r[i] == vtag_i);
         fill_match[i]   = valid_r[i] && (vtag_mem_r[i] == fill_vtag_i);
         if (lookup_match[i]) begin
            lookup_entry = lookup_entry | entry_mem_r[i];
         end
         if (fill_match[i]) begin
            fill_ptr = ptr_w'(i); // refill in place.
         end
      end
   end

   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         valid_r   <= '0;
         rr_ptr_r  <= '0;
         hit_vec_r <= '0;
      end else begin
         if (flush_i) begin
            valid_r <= '0;
         end else if (fill_v_i) begin
            valid_r[fill_ptr] <= 1'b1;
            if (!(|fill_match)) begin
               rr_ptr_r <= rr_ptr_r + 1'b1;
            end
         end
         if (lookup_v_i) begin
            hit_vec_r <= lookup_match;
         end
      end
   end

   always_ff @(posedge clk_i) begin
      if (fill_v_i) begin
         vtag_mem_r[fill_ptr]  <= fill_vtag_i;
         entry_mem_r[fill_ptr] <= fill_entry_i;
      end
      if (lookup_v_i) begin
         entry_o <= lookup_entry; // zero on a miss.
      end
   end

   assign hit_o = |hit_vec_r;

   // fill and fence come from separate commands.
   fill_flush_excl_a: assert property (@(posedge clk_i) disable iff (reset_i)
      !(fill_v_i && flush_i));

   // refill in place keeps vtags unique.
   hit_onehot_a: assert property (@(posedge clk_i) disable iff (reset_i)
      $onehot0(hit_vec_r));

endmodule

// ==== hw/pma_apb.sv ====
`include "fe_mem_cfg.svh"

module pma_apb (
   input  logic                   clk_i,
   input  logic                   reset_i,
   input  logic                   psel_i,
   input  logic                   penable_i,
   input  logic                   pwrite_i,
   input  logic [3:0]             paddr_i,
   input  logic [31:0]            pwdata_i,
   input  logic [`FE_PTAG_W-1:0]  ptag_i,
   output logic [31:0]            prdata_o,
   output logic                   pready_o,
   output logic                   pslverr_o,
   output logic                   uncached_o,
   output logic [7:0]             domain_o,
   output logic                   uncached_mode_o
);

   logic [7:0]  domain_r;
   logic        mode_r;
   logic        access;
   logic        known_addr;

   assign access     = psel_i && penable_i;
   assign known_addr = (paddr_i == `FE_APB_DOMAIN_ADDR) || (paddr_i == `FE_APB_MODE_ADDR);

   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         domain_r <= 8'h01; // only domain 0 on.
         mode_r   <= 1'b0;
      end else if (access && pwrite_i) begin
         if (paddr_i == `FE_APB_DOMAIN_ADDR) begin
            domain_r <= pwdata_i[7:0];
         end
         if (paddr_i == `FE_APB_MODE_ADDR) begin
            mode_r <= pwdata_i[0];
         end
      end
   end

   always_comb begin
      prdata_o = '0;
      if (paddr_i == `FE_APB_DOMAIN_ADDR) begin
         prdata_o[7:0] = domain_r;
      end else if (paddr_i == `FE_APB_MODE_ADDR) begin
         prdata_o[0] = mode_r;
      end
   end

   assign pready_o  = 1'b1; // single cycle access phase.
   assign pslverr_o = access && !known_addr;

   // top quarter of physical space is uncached.
   assign uncached_o      = (ptag_i[`FE_PTAG_W-1 -: 2] == 2'b11);
   assign domain_o        = domain_r;
   assign uncached_mode_o = mode_r;

endmodule

// ==== verif/fe_mem_checker.sv ====
module fe_mem_checker (
   input  logic               clk_i,
   input  logic               reset_i,
   input  logic               cmd_v_i,
   input  logic               cmd_yumi_i,
   input  fe_mem_pkg::fe_op_e cmd_op_i,
   input  logic               poison_i,
   input  logic               resp_v_i,
   input  logic [31:0]        resp_data_i,
   input  logic [3:0]         resp_flags_i, // itlb, icache, access, page.
   output int                 pass_cnt_o,
   output int                 fail_cnt_o,
   output int                 pending_o
);

   string       nxt_name;
   logic [31:0] nxt_data;
   logic [3:0]  nxt_flags;
   logic [3:0]  nxt_mask;
   logic        s1_v;
   string       s1_name;
   logic [31:0] s1_data;
   logic [3:0]  s1_flags;
   logic [3:0]  s1_mask;
   string       name_q [$];
   logic [31:0] data_q [$];
   logic [3:0]  flags_q [$];
   logic [3:0]  mask_q [$];
   logic        killed_q [$];
   int          due_q [$];
   int          cyc;

   // expectation for the next fetch that the port accepts.
   task set_expect(input string name, input logic [31:0] data, input logic [3:0] flags,
                   input logic [3:0] mask);
      nxt_name  = name;
      nxt_data  = data;
      nxt_flags = flags;
      nxt_mask  = mask;
   endtask

   task compare_head;
      string       name;
      logic [31:0] data;
      logic [3:0]  flags;
      logic [3:0]  mask;
      logic        killed;
      name   = name_q.pop_front();
      data   = data_q.pop_front();
      flags  = flags_q.pop_front();
      mask   = mask_q.pop_front();
      killed = killed_q.pop_front();
      due_q.delete(0);
      if (killed) begin
         if (resp_v_i) begin
            $display("ERROR %0s: poisoned fetch still produced a response", name);
            fail_cnt_o++;
         end else begin
            $display("PASS %0s: poisoned fetch gave no response", name);
            pass_cnt_o++;
         end
      end else if (!resp_v_i) begin
         $display("ERROR %0s: no response two cycles after the fetch was accepted", name);
         fail_cnt_o++;
      end else if (resp_data_i !== data || (resp_flags_i & mask) !== (flags & mask)) begin
         $display("CHECK FAILED %0s: expected data %h flags %b, actual data %h flags %b",
                  name, data, flags & mask, resp_data_i, resp_flags_i & mask);
         fail_cnt_o++;
      end else begin
         $display("PASS %0s: data %h flags %b", name, resp_data_i, resp_flags_i);
         pass_cnt_o++;
      end
   endtask

   always @(posedge clk_i) begin
      if (reset_i) begin
         s1_v       = 1'b0;
         cyc        = 0;
         pass_cnt_o = 0;
         fail_cnt_o = 0;
         pending_o  = 0;
         due_q.delete();
      end else begin
         if (due_q.size() > 0 && due_q[0] == cyc) begin
            compare_head();
         end else if (resp_v_i) begin
            $display("ERROR: response in cycle %0d with no fetch due", cyc);
            fail_cnt_o++;
         end
         // leaving stage 1, poison decides whether it answers.
         if (s1_v) begin
            name_q.push_back(s1_name);
            data_q.push_back(s1_data);
            flags_q.push_back(s1_flags);
            mask_q.push_back(s1_mask);
            killed_q.push_back(poison_i);
            due_q.push_back(cyc + 1);
         end
         s1_v = cmd_v_i && cmd_yumi_i && (cmd_op_i == fe_mem_pkg::op_fetch);
         if (s1_v) begin
            s1_name  = nxt_name;
            s1_data  = nxt_data;
            s1_flags = nxt_flags;
            s1_mask  = nxt_mask;
         end
         cyc++;
         pending_o = due_q.size() + int'(s1_v);
      end
   end

endmodule

// ==== verif/tb_fe_mem.sv ====
`include "fe_mem_cfg.svh"

module tb_fe_mem;

   localparam logic [4:0] ctl_s = 5'b00001; // supervisor, else user.
   localparam logic [4:0] ctl_x = 5'b00010; // translation on.
   localparam logic [4:0] ctl_p = 5'b00100; // poison in stage 1.
   localparam logic [4:0] ctl_c = 5'b01000; // next row goes back to back.
   localparam logic [4:0] ctl_u = 5'b10000; // uncached mode.
   localparam logic [3:0] f_none = 4'b0000;
   localparam logic [3:0] f_itlb = 4'b1000;
   localparam logic [3:0] f_ic   = 4'b0100;
   localparam logic [3:0] f_af   = 4'b0010;
   localparam logic [3:0] f_pf   = 4'b0001;
   localparam fe_mem_pkg::fe_op_e fetch_op  = fe_mem_pkg::op_fetch;
   localparam fe_mem_pkg::fe_op_e fill_op   = fe_mem_pkg::op_tlb_fill;
   localparam fe_mem_pkg::fe_op_e tfence_op = fe_mem_pkg::op_tlb_fence;
   localparam fe_mem_pkg::fe_op_e ifence_op = fe_mem_pkg::op_icache_fence;
   localparam int max_wait = 20;

   logic                   clk_i;
   logic                   reset_i;
   logic                   cmd_v_i;
   fe_mem_pkg::fe_op_e     cmd_op_i;
   logic [31:0]            cmd_vaddr_i;
   logic [19:0]            cmd_vtag_i;
   fe_mem_pkg::tlb_entry_s cmd_entry_i;
   logic                   cmd_yumi_o;
   fe_mem_pkg::priv_e      priv_i;
   logic                   translation_en_i;
   logic                   poison_i;
   logic                   psel_i;
   logic                   penable_i;
   logic                   pwrite_i;
   logic [3:0]             paddr_i;
   logic [31:0]            pwdata_i;
   logic [31:0]            prdata_o;
   logic                   pready_o;
   logic                   pslverr_o;
   logic                   fill_v_i;
   logic [3:0]             fill_index_i;
   logic [25:0]            fill_tag_i;
   logic [31:0]            fill_data_i;
   logic                   resp_v_o;
   logic [31:0]            resp_data_o;
   logic                   resp_itlb_miss_o;
   logic                   resp_icache_miss_o;
   logic                   resp_access_fault_o;
   logic                   resp_page_fault_o;
   int                     chk_pass;
   int                     chk_fail;
   int                     chk_pending;

   string              row_name [32];
   fe_mem_pkg::fe_op_e row_op [32];
   logic [31:0]        row_vaddr [32];
   logic [21:0]        row_fill [32];
   logic [4:0]         row_ctl [32];
   logic [3:0]         row_flags [32];
   logic [31:0]        row_data [32];
   int                 n_rows;
   int                 tb_pass;
   int                 tb_fail;
   integer             seed;
   logic [31:0]        w0;
   logic [31:0]        w1;
   logic [31:0]        apb_rdata;
   logic               apb_err;
   logic               cur_mode;

   fe_mem_top dut (.*);

   fe_mem_checker chk (
      .clk_i        (clk_i),
      .reset_i      (reset_i),
      .cmd_v_i      (cmd_v_i),
      .cmd_yumi_i   (cmd_yumi_o),
      .cmd_op_i     (cmd_op_i),
      .poison_i     (poison_i),
      .resp_v_i     (resp_v_o),
      .resp_data_i  (resp_data_o),
      .resp_flags_i ({resp_itlb_miss_o, resp_icache_miss_o, resp_access_fault_o,
                      resp_page_fault_o}),
      .pass_cnt_o   (chk_pass),
      .fail_cnt_o   (chk_fail),
      .pending_o    (chk_pending)
   );

   initial begin
      clk_i = 1'b0;
      forever #5 clk_i = ~clk_i;
   end

   task automatic wait_ready;
      int n;
      n = 0;
      @(posedge clk_i);
      while (!pready_o && n < max_wait) begin
         @(posedge clk_i);
         n++;
      end
      if (!pready_o) begin
         $display("ERROR: timeout, APB access not ready in %0d cycles", max_wait);
         tb_fail++;
      end
      apb_rdata = prdata_o;
      apb_err   = pslverr_o;
   endtask

   task automatic apb_write(input logic [3:0] addr, input logic [31:0] data);
      psel_i   = 1'b1;
      pwrite_i = 1'b1;
      paddr_i  = addr;
      pwdata_i = data;
      @(negedge clk_i);
      penable_i = 1'b1;
      wait_ready();
      @(negedge clk_i);
      psel_i    = 1'b0;
      penable_i = 1'b0;
      pwrite_i  = 1'b0;
   endtask

   task automatic apb_read(input string name, input logic [3:0] addr,
                           input logic [31:0] exp_data, input logic exp_err);
      psel_i   = 1'b1;
      pwrite_i = 1'b0;
      paddr_i  = addr;
      @(negedge clk_i);
      penable_i = 1'b1;
      wait_ready();
      @(negedge clk_i);
      psel_i    = 1'b0;
      penable_i = 1'b0;
      if (apb_rdata !== exp_data || apb_err !== exp_err) begin
         $display("CHECK FAILED %0s: expected data %h err %b, actual data %h err %b",
                  name, exp_data, exp_err, apb_rdata, apb_err);
         tb_fail++;
      end else begin
         $display("PASS %0s: data %h err %b", name, apb_rdata, apb_err);
         tb_pass++;
      end
   endtask

   task automatic fill_line(input logic [3:0] index, input logic [25:0] tag,
                            input logic [31:0] data);
      fill_v_i     = 1'b1;
      fill_index_i = index;
      fill_tag_i   = tag;
      fill_data_i  = data;
      @(negedge clk_i);
      fill_v_i = 1'b0;
   endtask

   task automatic add_row(input string name, input fe_mem_pkg::fe_op_e op,
                          input logic [31:0] vaddr, input logic [21:0] fill,
                          input logic [4:0] ctl, input logic [3:0] flags,
                          input logic [31:0] data);
      row_name[n_rows]  = name;
      row_op[n_rows]    = op;
      row_vaddr[n_rows] = vaddr;
      row_fill[n_rows]  = fill;
      row_ctl[n_rows]   = ctl;
      row_flags[n_rows] = flags;
      row_data[n_rows]  = data;
      n_rows++;
   endtask

   // lines 4 and 2 hold w0 at ptag 80000 and w1 at ptag 80001.
   task automatic build_table;
      add_row("hit_a", fetch_op, 32'h8000_0010, 22'h0, ctl_s, f_none, w0);
      add_row("hit_b", fetch_op, 32'h8000_1048, 22'h0, ctl_s, f_none, w1);
      add_row("miss_line", fetch_op, 32'h8000_0020, 22'h0, ctl_s, f_ic, 32'h0);
      add_row("below_dram", fetch_op, 32'h0000_1010, 22'h0, ctl_s, f_ic | f_af, 32'h0);
      add_row("domain_off", fetch_op, 32'ha000_0010, 22'h0, ctl_s, f_ic | f_af, 32'h0);
      add_row("uc_cached", fetch_op, 32'h8000_0010, 22'h0, ctl_s | ctl_u, f_af, w0);
      add_row("uc_uncached", fetch_op, 32'hc000_0010, 22'h0, ctl_s | ctl_u, f_ic, 32'h0);
      add_row("xlate_miss", fetch_op, 32'h0040_0010, 22'h0, ctl_s | ctl_x, f_itlb | f_ic, 0);
      add_row("fill_super", fill_op, 32'h0040_0000, {20'h80000, 1'b0, 1'b1}, 0, f_none, 0);
      add_row("xlate_hit", fetch_op, 32'h0040_0010, 22'h0, ctl_s | ctl_x, f_none, w0);
      add_row("pf_u_on_s", fetch_op, 32'h0040_0010, 22'h0, ctl_x, f_pf, w0);
      add_row("fill_user", fill_op, 32'h0040_1000, {20'h80001, 1'b1, 1'b1}, 0, f_none, 0);
      add_row("pf_s_on_u", fetch_op, 32'h0040_1048, 22'h0, ctl_s | ctl_x, f_pf, w1);
      add_row("user_ok", fetch_op, 32'h0040_1048, 22'h0, ctl_x, f_none, w1);
      add_row("fill_noexec", fill_op, 32'h0040_2000, {20'h80000, 1'b0, 1'b0}, 0, f_none, 0);
      add_row("pf_noexec", fetch_op, 32'h0040_2010, 22'h0, ctl_s | ctl_x, f_pf, w0);
      add_row("tlb_fence", tfence_op, 32'h0, 22'h0, 0, f_none, 32'h0);
      add_row("fenced_tlb", fetch_op, 32'h0040_0010, 22'h0, ctl_s | ctl_x, f_itlb | f_ic, 0);
      add_row("b2b_a", fetch_op, 32'h8000_0010, 22'h0, ctl_s | ctl_c, f_none, w0);
      add_row("b2b_b", fetch_op, 32'h8000_1048, 22'h0, ctl_s | ctl_c, f_none, w1);
      add_row("poison_mid", fetch_op, 32'h8000_0010, 22'h0, ctl_s | ctl_c | ctl_p, 0, w0);
      add_row("after_poison", fetch_op, 32'h8000_1048, 22'h0, ctl_s, f_none, w1);
      add_row("ic_fence", ifence_op, 32'h0, 22'h0, 0, f_none, 32'h0);
      add_row("fenced_line", fetch_op, 32'h8000_0010, 22'h0, ctl_s, f_ic, 32'h0);
   endtask

   task automatic wait_accept(input string name, output logic ok);
      int n;
      n = 0;
      @(posedge clk_i);
      while (!cmd_yumi_o && n < max_wait) begin
         @(posedge clk_i);
         n++;
      end
      ok = cmd_yumi_o;
      if (!ok) begin
         $display("ERROR %0s: timeout, command not accepted in %0d cycles", name, max_wait);
         tb_fail++;
      end
   endtask

   task automatic wait_idle(input string name);
      int n;
      n = 0;
      while (chk_pending != 0 && n < max_wait) begin
         @(negedge clk_i);
         n++;
      end
      if (chk_pending != 0) begin
         $display("ERROR %0s: timeout, fetch still in flight after %0d cycles", name, max_wait);
         tb_fail++;
      end
   endtask

   task automatic apply_rows;
      logic [3:0] mask;
      logic       ok;
      for (int i = 0; i < n_rows; i++) begin
         if (row_ctl[i][4] != cur_mode) begin
            apb_write(`FE_APB_MODE_ADDR, {31'b0, row_ctl[i][4]});
            cur_mode = row_ctl[i][4];
         end
         // ptag of a missed translation is unknown.
         mask = (row_ctl[i][1] && row_flags[i][3]) ? 4'b1101 : 4'b1111;
         chk.set_expect(row_name[i], row_data[i], row_flags[i], mask);
         cmd_v_i          = 1'b1;
         cmd_op_i         = row_op[i];
         cmd_vaddr_i      = row_vaddr[i];
         cmd_vtag_i       = row_vaddr[i][31:12];
         cmd_entry_i      = fe_mem_pkg::tlb_entry_s'(row_fill[i]);
         priv_i           = row_ctl[i][0] ? fe_mem_pkg::priv_s : fe_mem_pkg::priv_u;
         translation_en_i = row_ctl[i][1];
         wait_accept(row_name[i], ok);
         @(negedge clk_i);
         cmd_v_i  = 1'b0;
         poison_i = row_ctl[i][2]; // fetch sits in stage 1 now.
         if (ok && row_op[i] != fetch_op) begin
            $display("PASS %0s: command accepted", row_name[i]);
            tb_pass++;
         end
         if (!row_ctl[i][3]) begin
            @(negedge clk_i);
            poison_i = 1'b0;
            wait_idle(row_name[i]);
         end
      end
   endtask

   initial begin
      reset_i          = 1'b1;
      cmd_v_i          = 1'b0;
      cmd_op_i         = fetch_op;
      cmd_vaddr_i      = '0;
      cmd_vtag_i       = '0;
      cmd_entry_i      = '0;
      priv_i           = fe_mem_pkg::priv_s;
      translation_en_i = 1'b0;
      poison_i         = 1'b0;
      psel_i           = 1'b0;
      penable_i        = 1'b0;
      pwrite_i         = 1'b0;
      paddr_i          = '0;
      pwdata_i         = '0;
      fill_v_i         = 1'b0;
      fill_index_i     = '0;
      fill_tag_i       = '0;
      fill_data_i      = '0;
      tb_pass          = 0;
      tb_fail          = 0;
      n_rows           = 0;
      cur_mode         = 1'b0;
      seed             = 32'hc5c7_8e4b;
      w0               = $random(seed);
      w1               = $random(seed);
      repeat (4) @(negedge clk_i);
      reset_i = 1'b0;
      apb_write(`FE_APB_DOMAIN_ADDR, 32'h0000_00d0); // domains 4, 6 and 7.
      apb_write(`FE_APB_MODE_ADDR, 32'h1);
      apb_read("apb_domain", `FE_APB_DOMAIN_ADDR, 32'h0000_00d0, 1'b0);
      apb_read("apb_mode", `FE_APB_MODE_ADDR, 32'h1, 1'b0);
      apb_write(`FE_APB_MODE_ADDR, 32'h0);
      apb_read("apb_bad_addr", 4'h8, 32'h0, 1'b1);
      fill_line(4'd4, {20'h80000, 6'd0}, w0);
      fill_line(4'd2, {20'h80001, 6'd1}, w1);
      build_table();
      apply_rows();
      $display("%0d tests passed, %0d tests failed", tb_pass + chk_pass, tb_fail + chk_fail);
      if (tb_fail + chk_fail == 0) begin
         $display("Testbench passed");
      end else begin
         $display("Testbench failed");
      end
      $finish;
   end

endmodule
